//--- design/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// byte address width of the RAM
`define MEM_ADDR_WIDTH 16

// one byte per address
`define RAM_BYTES (1 << `MEM_ADDR_WIDTH)

// request queue depths per client
`define FETCH_QUEUE_DEPTH 2
`define DATA_QUEUE_DEPTH 2

`endif

//--- design/memTypesPkg.sv
`default_nettype none

`include "mem_consts.svh"

package memTypesPkg;

    // byte address into the RAM
    typedef logic [`MEM_ADDR_WIDTH-1:0] memAddr_t;

    // one RAM location
    typedef logic [7:0] memByte_t;

    // instruction or load/store data
    typedef logic [31:0] memWord_t;

endpackage

`default_nettype wire

//--- design/clientTypesPkg.sv
`default_nettype none

package clientTypesPkg;

    import memTypesPkg::*;

    // byte count is 1 << len
    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd2
    } accessLen_t;

    typedef struct packed {
        memAddr_t addr;
    } fetchReq_t;

    typedef struct packed {
        memAddr_t   addr;
        accessLen_t len;
        logic       store;
        memWord_t   wdata;
    } dataReq_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_LOAD,
        ST_STORE,
        ST_RESPOND
    } ctrlState_t;

endpackage

`default_nettype wire

//--- design/reqQueue.sv
`timescale 1ns/1ps
`default_nettype none

module reqQueue #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    output logic     inReady,
    input  payload_t inData,
    output logic     outValid,
    input  logic     outReady,
    output payload_t outData
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         slots [DEPTH];
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign outValid = (count != '0);
    assign outData  = slots[rdPtr];
    // a full queue still takes an entry while the head leaves
    assign inReady  = !full || outReady;
    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wrPtr] <= inData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/byteRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module byteRam
    import memTypesPkg::*;
(
    input  logic     clk,
    input  memAddr_t addr,
    input  logic     write,
    input  memByte_t wdata,
    output memByte_t rdata
);
    memByte_t bytes [`RAM_BYTES];

    always_ff @(posedge clk) begin
        if (write) begin
            bytes[addr] <= wdata;
        end
    end

    // read data lags the address by one cycle
    always_ff @(posedge clk) begin
        rdata <= bytes[addr];
    end

endmodule

`default_nettype wire

//--- design/memCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrl
    import memTypesPkg::*, clientTypesPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      ioStall,

    input  logic      fetchReqValid,
    output logic      fetchReqReady,
    input  fetchReq_t fetchReq,

    input  logic      dataReqValid,
    output logic      dataReqReady,
    input  dataReq_t  dataReq,

    output logic      fetchRespValid,
    input  logic      fetchRespReady,
    output memWord_t  fetchInst,

    output logic      dataRespValid,
    input  logic      dataRespReady,
    output memWord_t  dataRdata,

    output memAddr_t  memAddr,
    output logic      memWrite,
    output memByte_t  memWdata,
    input  memByte_t  memRdata
);
    ctrlState_t state;
    logic [2:0] stage;
    memAddr_t   reqAddr;
    accessLen_t reqLen;
    memWord_t   shiftWord;
    memWord_t   respWord;
    logic       fetchDone;
    logic       dataDone;

    logic       isIdle;
    logic       isRead;
    logic       takeData;
    logic       takeFetch;
    logic [2:0] reqBytes;
    logic [2:0] addrOffset;
    logic       readLast;
    logic       storeLast;
    logic       respTaken;
    memWord_t   assembled;

    // bytes arrive lsb first, so a short load sits in the top bytes
    function automatic memWord_t alignLoad(input memWord_t word, input accessLen_t len);
        case (len)
            LEN_BYTE: return {24'h0, word[31:24]};
            LEN_HALF: return {16'h0, word[31:16]};
            default:  return word;
        endcase
    endfunction

    assign isIdle   = (state == ST_IDLE);
    assign isRead   = (state == ST_FETCH) || (state == ST_LOAD);
    assign reqBytes = 3'd1 << reqLen;

    // data client wins when both wait
    assign dataReqReady  = isIdle && !ioStall;
    assign fetchReqReady = isIdle && !ioStall && !dataReqValid;
    assign takeData      = dataReqValid && dataReqReady;
    assign takeFetch     = fetchReqValid && fetchReqReady;

    // stage 0 only issues the first address, the last stage only captures
    assign readLast  = isRead && (stage == reqBytes);
    assign storeLast = (state == ST_STORE) && (stage == reqBytes - 3'd1);

    // on stall re-present the last read address so the RAM repeats its byte
    assign addrOffset = (ioStall && stage != 3'd0) ? stage - 3'd1 : stage;
    assign memAddr    = reqAddr + memAddr_t'(addrOffset);
    assign memWrite   = (state == ST_STORE) && !ioStall;
    assign memWdata   = shiftWord[7:0];

    assign assembled = {memRdata, shiftWord[31:8]};

    // response held in its register, hidden while the bus is stalled
    assign fetchRespValid = fetchDone && !ioStall;
    assign dataRespValid  = dataDone && !ioStall;
    assign fetchInst      = respWord;
    assign dataRdata      = respWord;
    assign respTaken      = (fetchRespValid && fetchRespReady)
                         || (dataRespValid && dataRespReady);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            stage     <= 3'd0;
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
        end else if (!ioStall) begin
            case (state)
                ST_IDLE: begin
                    stage <= 3'd0;
                    if (takeData) begin
                        state <= dataReq.store ? ST_STORE : ST_LOAD;
                    end else if (takeFetch) begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH,
                ST_LOAD: begin
                    if (readLast) begin
                        state     <= ST_RESPOND;
                        fetchDone <= (state == ST_FETCH);
                        dataDone  <= (state == ST_LOAD);
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                ST_STORE: begin
                    if (storeLast) begin
                        state    <= ST_RESPOND;
                        dataDone <= 1'b1;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                ST_RESPOND: begin
                    if (respTaken) begin
                        state     <= ST_IDLE;
                        fetchDone <= 1'b0;
                        dataDone  <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // request latch, byte shifter and response word
    always_ff @(posedge clk) begin
        if (!ioStall) begin
            if (takeData) begin
                reqAddr   <= dataReq.addr;
                reqLen    <= dataReq.len;
                shiftWord <= dataReq.wdata;
            end else if (takeFetch) begin
                reqAddr <= fetchReq.addr;
                reqLen  <= LEN_WORD;
            end else if (isRead && stage != 3'd0) begin
                shiftWord <= assembled;
            end else if (state == ST_STORE) begin
                shiftWord <= {8'h00, shiftWord[31:8]};
            end

            if (readLast) begin
                respWord <= alignLoad(assembled, reqLen);
            end else if (storeLast) begin
                respWord <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module memSubsystem
    import memTypesPkg::*, clientTypesPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      ioStall,

    input  logic      fetchReqValid,
    output logic      fetchReqReady,
    input  fetchReq_t fetchReq,

    input  logic      dataReqValid,
    output logic      dataReqReady,
    input  dataReq_t  dataReq,

    output logic      fetchRespValid,
    input  logic      fetchRespReady,
    output memWord_t  fetchInst,

    output logic      dataRespValid,
    input  logic      dataRespReady,
    output memWord_t  dataRdata
);
    // queue to controller
    logic      qFetchValid;
    logic      qFetchReady;
    fetchReq_t qFetch;
    logic      qDataValid;
    logic      qDataReady;
    dataReq_t  qData;

    // byte bus
    memAddr_t  memAddr;
    logic      memWrite;
    memByte_t  memWdata;
    memByte_t  memRdata;

    reqQueue #(
        .payload_t (fetchReq_t),
        .DEPTH     (`FETCH_QUEUE_DEPTH)
    ) fetchQueue (
        .clk      (clk),
        .rst      (rst),
        .inValid  (fetchReqValid),
        .inReady  (fetchReqReady),
        .inData   (fetchReq),
        .outValid (qFetchValid),
        .outReady (qFetchReady),
        .outData  (qFetch)
    );

    reqQueue #(
        .payload_t (dataReq_t),
        .DEPTH     (`DATA_QUEUE_DEPTH)
    ) dataQueue (
        .clk      (clk),
        .rst      (rst),
        .inValid  (dataReqValid),
        .inReady  (dataReqReady),
        .inData   (dataReq),
        .outValid (qDataValid),
        .outReady (qDataReady),
        .outData  (qData)
    );

    memCtrl ctrl (
        .clk            (clk),
        .rst            (rst),
        .ioStall        (ioStall),
        .fetchReqValid  (qFetchValid),
        .fetchReqReady  (qFetchReady),
        .fetchReq       (qFetch),
        .dataReqValid   (qDataValid),
        .dataReqReady   (qDataReady),
        .dataReq        (qData),
        .fetchRespValid (fetchRespValid),
        .fetchRespReady (fetchRespReady),
        .fetchInst      (fetchInst),
        .dataRespValid  (dataRespValid),
        .dataRespReady  (dataRespReady),
        .dataRdata      (dataRdata),
        .memAddr        (memAddr),
        .memWrite       (memWrite),
        .memWdata       (memWdata),
        .memRdata       (memRdata)
    );

    byteRam ram (
        .clk   (clk),
        .addr  (memAddr),
        .write (memWrite),
        .wdata (memWdata),
        .rdata (memRdata)
    );

endmodule

`default_nettype wire

//--- verif/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module memSubsystemTb
    import memTypesPkg::*, clientTypesPkg::*;
();
    localparam int TIMEOUT = 200;

    logic      clk;
    logic      rst;
    logic      ioStall;
    logic      fetchReqValid;
    logic      fetchReqReady;
    fetchReq_t fetchReq;
    logic      dataReqValid;
    logic      dataReqReady;
    dataReq_t  dataReq;
    logic      fetchRespValid;
    logic      fetchRespReady;
    memWord_t  fetchInst;
    logic      dataRespValid;
    logic      dataRespReady;
    memWord_t  dataRdata;

    // reference copy of the RAM
    memByte_t    model [`RAM_BYTES];
    memWord_t    expData [$];
    memWord_t    expFetch [$];
    memWord_t    gotData [$];
    memWord_t    gotFetch [$];
    logic        gotOrder [$];
    logic [31:0] lfsr;
    memAddr_t    wordBase;
    memAddr_t    mixBase;
    int          errors;
    int          checks;
    int          tests;

    memSubsystem i_dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // responses sampled mid-cycle before the accepting edge
    always @(negedge clk) begin
        if (!rst && dataRespValid && dataRespReady) begin
            gotData.push_back(dataRdata);
            gotOrder.push_back(1'b1);
        end
        if (!rst && fetchRespValid && fetchRespReady) begin
            gotFetch.push_back(fetchInst);
            gotOrder.push_back(1'b0);
        end
    end

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic memAddr_t randAligned();
        return memAddr_t'(randBits(14) << 2);
    endfunction

    function automatic int byteCount(input accessLen_t len);
        case (len)
            LEN_BYTE: return 1;
            LEN_HALF: return 2;
            default:  return 4;
        endcase
    endfunction

    // little endian, zero extended
    function automatic memWord_t modelRead(input memAddr_t addr, input accessLen_t len);
        memWord_t w;
        w = '0;
        for (int k = 0; k < byteCount(len); k++) begin
            w[8*k +: 8] = model[addr + memAddr_t'(k)];
        end
        return w;
    endfunction

    function automatic dataReq_t makeReq(input memAddr_t addr, input accessLen_t len,
                                         input logic store, input memWord_t wdata);
        dataReq_t req;
        req.addr  = addr;
        req.len   = len;
        req.store = store;
        req.wdata = wdata;
        return req;
    endfunction

    task automatic reportError(input string what);
        errors++;
        $display("ERROR: %s", what);
    endtask

    task automatic checkWord(input string name, input memWord_t exp, input memWord_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic checkOrder(input string name, input logic expDataFirst,
                              input logic gotDataFirst);
        checks++;
        if (gotDataFirst !== expDataFirst) begin
            errors++;
            $display("[FAIL] %s: expected %s response first, actual %s response first", name,
                     expDataFirst ? "data" : "fetch", gotDataFirst ? "data" : "fetch");
        end
    endtask

    task automatic sendData(input dataReq_t req);
        int n;
        n = 0;
        @(posedge clk);
        dataReqValid <= 1'b1;
        dataReq      <= req;
        @(negedge clk);
        while (!dataReqReady && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!dataReqReady) begin
            reportError("data request was never accepted");
        end
        @(posedge clk);
        dataReqValid <= 1'b0;
    endtask

    task automatic sendFetch(input memAddr_t addr);
        int n;
        n = 0;
        @(posedge clk);
        fetchReqValid <= 1'b1;
        fetchReq.addr <= addr;
        @(negedge clk);
        while (!fetchReqReady && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!fetchReqReady) begin
            reportError("fetch request was never accepted");
        end
        @(posedge clk);
        fetchReqValid <= 1'b0;
    endtask

    // expected value is taken from the model in request order
    task automatic issueData(input memAddr_t addr, input accessLen_t len, input logic store,
                             input memWord_t wdata);
        if (store) begin
            for (int k = 0; k < byteCount(len); k++) begin
                model[addr + memAddr_t'(k)] = wdata[8*k +: 8];
            end
            expData.push_back('0);
        end else begin
            expData.push_back(modelRead(addr, len));
        end
        sendData(makeReq(addr, len, store, wdata));
    endtask

    task automatic issueFetch(input memAddr_t addr);
        expFetch.push_back(modelRead(addr, LEN_WORD));
        sendFetch(addr);
    endtask

    // waits for all outstanding responses, then compares them in order
    task automatic drain(input string name);
        int n;
        n = 0;
        while ((gotData.size() < expData.size() || gotFetch.size() < expFetch.size())
               && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (gotData.size() < expData.size() || gotFetch.size() < expFetch.size()) begin
            reportError($sformatf("%s: responses missing after timeout", name));
        end
        while (expData.size() > 0 && gotData.size() > 0) begin
            checkWord(name, expData.pop_front(), gotData.pop_front());
        end
        while (expFetch.size() > 0 && gotFetch.size() > 0) begin
            checkWord(name, expFetch.pop_front(), gotFetch.pop_front());
        end
        if (gotData.size() > 0 || gotFetch.size() > 0) begin
            reportError($sformatf("%s: more responses than requests", name));
        end
        expData.delete();
        expFetch.delete();
        gotData.delete();
        gotFetch.delete();
    endtask

    task automatic holdStall(input int cycles);
        repeat (2) @(posedge clk);
        ioStall <= 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            if (dataRespValid || fetchRespValid) begin
                reportError("response valid while the stall input was high");
            end
        end
        @(posedge clk);
        ioStall <= 1'b0;
    endtask

    task automatic finishTest(input string name, input int errBefore);
        tests++;
        $display("test %-20s %0d error(s)", name, errors - errBefore);
    endtask

    task automatic testWordStoreLoad();
        int e0;
        e0 = errors;
        wordBase = randAligned();
        issueData(wordBase, LEN_WORD, 1'b1, randBits(32));
        issueData(wordBase, LEN_WORD, 1'b0, '0);
        drain("word store/load");
        finishTest("word store/load", e0);
    endtask

    task automatic testByteHalf();
        int e0;
        e0 = errors;
        mixBase = randAligned();
        issueData(mixBase, LEN_WORD, 1'b1, randBits(32));
        // upper store bits are random and must not reach the RAM
        issueData(mixBase + memAddr_t'(randBits(2)), LEN_BYTE, 1'b1, randBits(32));
        issueData(mixBase + memAddr_t'(randBits(1) << 1), LEN_HALF, 1'b1, randBits(32));
        issueData(mixBase + memAddr_t'(randBits(2)), LEN_BYTE, 1'b0, '0);
        issueData(mixBase + memAddr_t'(randBits(1) << 1), LEN_HALF, 1'b0, '0);
        issueData(mixBase, LEN_WORD, 1'b0, '0);
        drain("byte/half access");
        finishTest("byte/half access", e0);
    endtask

    task automatic testFetch();
        int e0;
        e0 = errors;
        issueFetch(mixBase);
        issueFetch(wordBase);
        drain("instruction fetch");
        finishTest("instruction fetch", e0);
    endtask

    task automatic testPriority();
        int e0;
        int n;
        e0 = errors;
        n = 0;
        gotOrder.delete();
        expData.push_back(modelRead(wordBase, LEN_WORD));
        expFetch.push_back(modelRead(mixBase, LEN_WORD));
        @(posedge clk);
        dataReqValid  <= 1'b1;
        dataReq       <= makeReq(wordBase, LEN_WORD, 1'b0, '0);
        fetchReqValid <= 1'b1;
        fetchReq.addr <= mixBase;
        @(negedge clk);
        while (!(dataReqReady && fetchReqReady) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!(dataReqReady && fetchReqReady)) begin
            reportError("simultaneous requests were not both accepted");
        end
        @(posedge clk);
        dataReqValid  <= 1'b0;
        fetchReqValid <= 1'b0;
        drain("data priority");
        if (gotOrder.size() > 0) begin
            checkOrder("data priority", 1'b1, gotOrder[0]);
        end
        finishTest("data priority", e0);
    endtask

    task automatic testBackPressure();
        int       e0;
        int       n;
        e0 = errors;
        n = 0;
        @(posedge clk);
        dataRespReady <= 1'b0;
        issueData(wordBase, LEN_WORD, 1'b0, '0);
        issueData(mixBase, LEN_HALF, 1'b0, '0);
        issueData(mixBase + memAddr_t'(3), LEN_BYTE, 1'b0, '0);
        @(negedge clk);
        while ((dataReqReady || !dataRespValid) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (dataReqReady || !dataRespValid) begin
            reportError("request queue did not fill while the response was held");
        end
        // held response must match the oldest request
        repeat (8) begin
            @(negedge clk);
            if (!dataRespValid) begin
                reportError("data response dropped before it was accepted");
            end
            checkWord("response back-pressure", expData[0], dataRdata);
        end
        @(posedge clk);
        dataRespReady <= 1'b1;
        drain("response back-pressure");
        finishTest("response back-pressure", e0);
    endtask

    task automatic testStall();
        int       e0;
        memAddr_t a;
        e0 = errors;
        a = randAligned();
        issueData(a, LEN_WORD, 1'b1, randBits(32));
        holdStall(5);
        drain("stall");
        issueData(a, LEN_WORD, 1'b0, '0);
        holdStall(5);
        drain("stall");
        finishTest("stall", e0);
    endtask

    initial begin
        lfsr   = 32'd76470;
        errors = 0;
        checks = 0;
        tests  = 0;
        rst            <= 1'b1;
        ioStall        <= 1'b0;
        fetchReqValid  <= 1'b0;
        fetchReq       <= '0;
        dataReqValid   <= 1'b0;
        dataReq        <= '0;
        fetchRespReady <= 1'b1;
        dataRespReady  <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        testWordStoreLoad();
        testByteHalf();
        testFetch();
        testPriority();
        testBackPressure();
        testStall();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/memTypesPkg.sv
design/clientTypesPkg.sv
design/reqQueue.sv
design/byteRam.sv
design/memCtrl.sv
design/memSubsystem.sv
verif/memSubsystemTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module memSubsystemTb \
    > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/VmemSubsystemTb 2>&1 | tee sim.log
grep -qx "Finished with no errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
